/* logic/gpio_pkg.sv */
package gpio_pkg;

    // Register regions of the GPIO core, listed in address order.
    // The core turns an internal offset into one of these before it
    // touches a register, so reads and writes share the same decode.
    typedef enum logic [2:0] {
        region_version   = 3'd0,  // Offset zero. A write here is a soft reset.
        region_input     = 3'd1,  // Raw pin readback, one byte per eight pins.
        region_output    = 3'd2,  // Output values.
        region_direction = 3'd3,  // Drive enables for the tristate pins.
        region_none      = 3'd4   // Anything past the last direction byte.
    } gpio_region_e;

    // States of the Wishbone bridge.
    // st_idle waits for a request, st_access carries the internal strobe
    // for one cycle, and st_ack returns the acknowledge for one cycle.
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_access = 2'd1,
        st_ack    = 2'd2
    } bridge_state_e;

    // Version byte read back at offset zero.
    localparam logic [7:0] gpio_version = 8'h00;

endpackage

/* logic/wb_to_ip.sv */
module wb_to_ip #(
    parameter int                   abuswidth = 16,
    parameter logic [abuswidth-1:0] base_addr = '0,
    parameter logic [abuswidth-1:0] high_addr = '1
) (
    input  logic                 BUS_CLK,
    input  logic                 RST,

    input  logic [abuswidth-1:0] wb_adr,
    input  logic [7:0]           wb_dat_i,
    output logic [7:0]           wb_dat_o,
    input  logic                 wb_we,
    input  logic                 wb_stb,
    input  logic                 wb_cyc,
    output logic                 wb_ack,

    output logic [abuswidth-1:0] ip_add,
    output logic [7:0]           ip_data_in,
    input  logic [7:0]           ip_data_out,
    output logic                 ip_rd,
    output logic                 ip_wr
);

    gpio_pkg::bridge_state_e state;

    logic new_req;    // Master has a cycle open on this slave.
    logic in_window;  // Current address falls between the window bounds.
    logic req_hit;    // Latched window result for the request in flight.
    logic req_we;     // Latched direction of the request in flight.

    assign new_req   = wb_cyc && wb_stb;
    assign in_window = (wb_adr >= base_addr) && (wb_adr <= high_addr);

    // The request is only sampled in st_idle. After the acknowledge the
    // machine spends one cycle back in st_idle, which is the cycle in which
    // the master drops its strobe or sets up the next transfer.
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            state <= gpio_pkg::st_idle;
        end else begin
            case (state)
                gpio_pkg::st_idle: begin
                    if (new_req) begin
                        state <= gpio_pkg::st_access;
                    end
                end
                gpio_pkg::st_access: state <= gpio_pkg::st_ack;
                default:             state <= gpio_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            req_hit <= 1'b0;
            req_we  <= 1'b0;
        end else if (state == gpio_pkg::st_idle && new_req) begin
            req_hit <= in_window;  // The window is checked once per transfer.
            req_we  <= wb_we;
        end
    end

    // Offset and write data are held for the whole transfer.
    always_ff @(posedge BUS_CLK) begin
        if (state == gpio_pkg::st_idle && new_req) begin
            ip_add     <= wb_adr - base_addr;
            ip_data_in <= wb_dat_i;
        end
    end

    // One strobe per transfer, and none at all for an access outside the window.
    assign ip_rd = (state == gpio_pkg::st_access) && req_hit && !req_we;
    assign ip_wr = (state == gpio_pkg::st_access) && req_hit && req_we;

    assign wb_ack = (state == gpio_pkg::st_ack);

    // The core already holds the read byte by the time the acknowledge is up.
    assign wb_dat_o = (wb_ack && req_hit && !req_we) ? ip_data_out : 8'h00;

    // An acknowledge always belongs to a cycle the master still holds open.
    assert property (@(posedge BUS_CLK) disable iff (RST)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack raised without an open Wishbone cycle.");

    assert property (@(posedge BUS_CLK) disable iff (RST)
        !(ip_rd && ip_wr))
        else $error("ip_rd and ip_wr raised together.");

    assert property (@(posedge BUS_CLK) disable iff (RST)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for more than one cycle.");

endmodule

/* logic/gpio_core.sv */
module gpio_core #(
    parameter int                  abuswidth    = 16,
    parameter int                  io_width     = 8,
    parameter logic [io_width-1:0] io_direction = '0,
    parameter logic [io_width-1:0] io_tri       = '0
) (
    input  logic                 BUS_CLK,
    input  logic                 RST,

    input  logic [abuswidth-1:0] ip_add,
    input  logic [7:0]           ip_data_in,
    output logic [7:0]           ip_data_out,
    input  logic                 ip_rd,
    input  logic                 ip_wr,

    inout  wire  [io_width-1:0]  io
);

    // Address map, with B bytes per region:
    //   0           version on read, soft reset on write
    //   1 .. B      input readback
    //   B+1 .. 2B   output bytes
    //   2B+1 .. 3B  direction bytes
    localparam int io_bytes  = (io_width + 7) / 8;
    localparam int idx_width = (io_bytes > 1) ? $clog2(io_bytes) : 1;
    localparam int reg_width = io_bytes * 8;

    gpio_pkg::gpio_region_e region;

    logic [idx_width-1:0] byte_idx;       // Byte within the decoded region.
    logic [abuswidth-1:0] rel_input;
    logic [abuswidth-1:0] rel_output;
    logic [abuswidth-1:0] rel_direction;

    logic [reg_width-1:0] out_reg;        // Byte n covers pins 8n to 8n+7.
    logic [reg_width-1:0] dir_reg;
    logic [reg_width-1:0] pin_in;         // Pins padded up to whole bytes.
    logic [io_width-1:0]  pin_oe;         // Per-pin drive enable.

    logic soft_rst;
    logic clear;

    // Offsets relative to the start of each region.
    // Lower offsets wrap to large values and fail the range test below.
    assign rel_input     = ip_add - abuswidth'(1);
    assign rel_output    = ip_add - abuswidth'(1 + io_bytes);
    assign rel_direction = ip_add - abuswidth'(1 + 2 * io_bytes);

    always_comb begin
        region   = gpio_pkg::region_none;
        byte_idx = '0;
        if (ip_add == '0) begin
            region = gpio_pkg::region_version;
        end else if (rel_input < abuswidth'(io_bytes)) begin
            region   = gpio_pkg::region_input;
            byte_idx = rel_input[idx_width-1:0];
        end else if (rel_output < abuswidth'(io_bytes)) begin
            region   = gpio_pkg::region_output;
            byte_idx = rel_output[idx_width-1:0];
        end else if (rel_direction < abuswidth'(io_bytes)) begin
            region   = gpio_pkg::region_direction;
            byte_idx = rel_direction[idx_width-1:0];
        end
    end

    // Readback takes the pins as they are, with no synchronizer in front.
    always_comb begin
        pin_in               = '0;
        pin_in[io_width-1:0] = io;  // Bits past the last pin stay zero.
    end

    assign soft_rst = ip_wr && (region == gpio_pkg::region_version);
    assign clear    = RST || soft_rst;

    // A soft reset has the same effect on the registers as RST.
    always_ff @(posedge BUS_CLK) begin
        if (clear) begin
            out_reg <= '0;
            dir_reg <= '0;
        end else if (ip_wr) begin
            case (region)
                gpio_pkg::region_output: begin
                    out_reg[byte_idx*8 +: 8] <= ip_data_in;
                end
                gpio_pkg::region_direction: begin
                    dir_reg[byte_idx*8 +: 8] <= ip_data_in;
                end
                default: begin
                    // The input region and unmapped offsets ignore writes.
                end
            endcase
        end
    end

    // Read data is captured on the strobe edge and held for the bridge.
    always_ff @(posedge BUS_CLK) begin
        if (ip_rd) begin
            case (region)
                gpio_pkg::region_version: begin
                    ip_data_out <= gpio_pkg::gpio_version;
                end
                gpio_pkg::region_input: begin
                    ip_data_out <= pin_in[byte_idx*8 +: 8];
                end
                gpio_pkg::region_output: begin
                    ip_data_out <= out_reg[byte_idx*8 +: 8];
                end
                gpio_pkg::region_direction: begin
                    ip_data_out <= dir_reg[byte_idx*8 +: 8];
                end
                default: begin
                    ip_data_out <= 8'h00;
                end
            endcase
        end
    end

    // A tristate pin follows its direction bit. An always-driven pin is
    // enabled for good, and a pin in neither mask is an input only.
    // When a pin sits in both masks the tristate control wins.
    always_comb begin
        for (int i = 0; i < io_width; i++) begin
            pin_oe[i] = io_tri[i] ? dir_reg[i] : io_direction[i];
        end
    end

    for (genvar i = 0; i < io_width; i++) begin : g_pin
        if (io_tri[i] || io_direction[i]) begin : g_drv
            assign io[i] = pin_oe[i] ? out_reg[i] : 1'bz;
        end
    end

    assert property (@(posedge BUS_CLK)
        (pin_oe & ~(io_direction | io_tri)) == '0)
        else $error("Core drives a pin that is configured as input only.");

endmodule

/* logic/gpio_wb_top.sv */
module gpio_wb_top #(
    parameter int                   abuswidth    = 16,
    parameter logic [abuswidth-1:0] base_addr    = 16'h1000,
    parameter logic [abuswidth-1:0] high_addr    = 16'h100F,
    parameter int                   io_width     = 12,
    parameter logic [io_width-1:0]  io_direction = '0,
    parameter logic [io_width-1:0]  io_tri       = '0
) (
    input  logic                 BUS_CLK,
    input  logic                 RST,

    input  logic [abuswidth-1:0] wb_adr,
    input  logic [7:0]           wb_dat_i,
    output logic [7:0]           wb_dat_o,
    input  logic                 wb_we,
    input  logic                 wb_stb,
    input  logic                 wb_cyc,
    output logic                 wb_ack,

    inout  wire  [io_width-1:0]  io
);

    // Internal register bus between the bridge and the core.
    logic [abuswidth-1:0] ip_add;      // Offset from base_addr.
    logic [7:0]           ip_data_in;
    logic [7:0]           ip_data_out;
    logic                 ip_rd;
    logic                 ip_wr;

    // The window bounds matter only to the bridge.
    wb_to_ip #(
        .abuswidth (abuswidth),
        .base_addr (base_addr),
        .high_addr (high_addr)
    ) wb_to_ip_i (
        .BUS_CLK     (BUS_CLK),
        .RST         (RST),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_we       (wb_we),
        .wb_stb      (wb_stb),
        .wb_cyc      (wb_cyc),
        .wb_ack      (wb_ack),
        .ip_add      (ip_add),
        .ip_data_in  (ip_data_in),
        .ip_data_out (ip_data_out),
        .ip_rd       (ip_rd),
        .ip_wr       (ip_wr)
    );

    gpio_core #(
        .abuswidth    (abuswidth),
        .io_width     (io_width),
        .io_direction (io_direction),
        .io_tri       (io_tri)
    ) gpio_core_i (
        .BUS_CLK     (BUS_CLK),
        .RST         (RST),
        .ip_add      (ip_add),
        .ip_data_in  (ip_data_in),
        .ip_data_out (ip_data_out),
        .ip_rd       (ip_rd),
        .ip_wr       (ip_wr),
        .io          (io)
    );

endmodule

/* tests/gpio_checker.sv */
module gpio_checker #(
    parameter int                   abuswidth = 16,
    parameter logic [abuswidth-1:0] base_addr = 16'h1000,
    parameter logic [abuswidth-1:0] high_addr = 16'h100F,
    parameter int                   io_width  = 12
) (
    input  logic                 BUS_CLK,
    input  logic                 RST,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_ack,
    input  logic [7:0]           wb_dat_o,
    input  wire  [io_width-1:0]  io,
    input  logic [1:0]           exp_kind,
    input  logic [abuswidth-1:0] exp_addr,
    input  logic [io_width-1:0]  exp_value,
    input  logic [io_width-1:0]  exp_mask,
    input  logic [8*24-1:0]      test_name,
    input  logic                 test_end,
    input  logic                 run_end,
    output int                   failed_tests
);

    int         req_age   = 0;     // Rising edges since the request was first seen.
    logic       ack_seen  = 1'b0;
    int         test_errs = 0;
    int         err_code  = 0;     // First problem of the test. 0 is a wrong value.
    int         err_exp   = 0;
    int         err_act   = 0;
    int         tests_run = 0;
    int         checks    = 0;
    logic [7:0] want;

    initial failed_tests = 0;

    // Region of a bus address in the map with B bytes per region.
    function automatic gpio_pkg::gpio_region_e region_of(input logic [abuswidth-1:0] addr);
        gpio_pkg::gpio_region_e region;
        int                     off;
        int                     nbytes;
        off    = int'(addr - base_addr);
        nbytes = (io_width + 7) / 8;
        if (addr < base_addr || addr > high_addr) region = gpio_pkg::region_none;
        else if (off == 0)                        region = gpio_pkg::region_version;
        else if (off <= nbytes)                   region = gpio_pkg::region_input;
        else if (off <= 2 * nbytes)               region = gpio_pkg::region_output;
        else if (off <= 3 * nbytes)               region = gpio_pkg::region_direction;
        else                                      region = gpio_pkg::region_none;
        return region;
    endfunction

    task automatic note_error(input int code, input int expected, input int actual);
        if (test_errs == 0) begin
            err_code = code;
            err_exp  = expected;
            err_act  = actual;
        end
        test_errs++;
    endtask

    task automatic report_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("Pass %0s", test_name);
        end else begin
            failed_tests++;
            case (err_code)
                0: $display("Fail %0s: expected %0h, actual %0h", test_name, err_exp, err_act);
                1: $display("Test %0s: acknowledge came %0d cycles after the request, not 2.",
                            test_name, err_act);
                2: $display("Test %0s: acknowledge raised with no open bus cycle.", test_name);
                default: $display("Test %0s: acknowledge stayed high for two cycles.", test_name);
            endcase
        end
        test_errs = 0;
    endtask

    always @(posedge BUS_CLK) begin
        if (RST) begin
            req_age  = 0;
            ack_seen = 1'b0;
        end else begin
            if (wb_ack) begin
                if (!(wb_cyc && wb_stb)) note_error(2, 0, 0);
                else if (ack_seen)       note_error(3, 0, 0);
                else if (req_age != 2)   note_error(1, 2, req_age);
                req_age = 0;
                if (exp_kind == 2'd1) begin
                    // Version and unmapped addresses have fixed read data.
                    case (region_of(exp_addr))
                        gpio_pkg::region_version: want = gpio_pkg::gpio_version;
                        gpio_pkg::region_none:    want = 8'h00;
                        default:                  want = exp_value[7:0];
                    endcase
                    checks++;
                    if (wb_dat_o !== want) note_error(0, want, wb_dat_o);
                end
            end else if (wb_cyc && wb_stb) begin
                req_age = req_age + 1;
            end
            ack_seen = wb_ack;
            if (exp_kind == 2'd2) begin
                checks++;
                if ((io & exp_mask) !== (exp_value & exp_mask)) begin
                    note_error(0, exp_value & exp_mask, io & exp_mask);
                end
            end
            if (test_end) report_test();
            if (run_end) begin
                $display("Tests: %0d run, %0d passed, %0d failed, %0d checks.",
                         tests_run, tests_run - failed_tests, failed_tests, checks);
            end
        end
    end

endmodule

/* tests/tb_gpio.sv */
module tb_gpio;

    localparam int          abuswidth = 16;
    localparam int          io_width  = 12;
    localparam logic [15:0] base_addr = 16'h1000;
    localparam logic [15:0] high_addr = 16'h100F;

    logic                BUS_CLK;
    logic                RST;
    logic [15:0]         wb_adr;
    logic [7:0]          wb_dat_i;
    logic [7:0]          wb_dat_o;
    logic                wb_we;
    logic                wb_stb;
    logic                wb_cyc;
    logic                wb_ack;
    wire  [io_width-1:0] io;

    logic [io_width-1:0] drv_val;      // Values the testbench puts on the pins.
    logic [io_width-1:0] drv_en;       // Pins the testbench drives.

    // Expectation handed to the checker. Kind 1 is read data, kind 2 is pins.
    logic [1:0]          exp_kind;
    logic [15:0]         exp_addr;
    logic [io_width-1:0] exp_value;
    logic [io_width-1:0] exp_mask;
    logic [8*24-1:0]     test_name;
    logic                test_end;
    logic                run_end;
    int                  failed_tests;

    int                  cycles      = 0;
    int                  cycle_limit = 0;
    int                  line_count  = 0;
    int                  line_errors = 0;
    int                  fd;
    int                  n;
    logic [8*96-1:0]     line_buf;
    logic [8*16-1:0]     op;
    logic                in_test = 1'b0;

    always #2 BUS_CLK = ~BUS_CLK;

    gpio_wb_top #(
        .abuswidth    (abuswidth),
        .base_addr    (base_addr),
        .high_addr    (high_addr),
        .io_width     (io_width),
        .io_direction (12'h00F),   // Pins 0 to 3 always drive.
        .io_tri       (12'h0F0)    // Pins 4 to 7 follow their direction bits.
    ) gpio_wb_top_i (
        .BUS_CLK  (BUS_CLK),
        .RST      (RST),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_we    (wb_we),
        .wb_stb   (wb_stb),
        .wb_cyc   (wb_cyc),
        .wb_ack   (wb_ack),
        .io       (io)
    );

    gpio_checker #(
        .abuswidth (abuswidth),
        .base_addr (base_addr),
        .high_addr (high_addr),
        .io_width  (io_width)
    ) gpio_checker_i (
        .BUS_CLK      (BUS_CLK),
        .RST          (RST),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_ack       (wb_ack),
        .wb_dat_o     (wb_dat_o),
        .io           (io),
        .exp_kind     (exp_kind),
        .exp_addr     (exp_addr),
        .exp_value    (exp_value),
        .exp_mask     (exp_mask),
        .test_name    (test_name),
        .test_end     (test_end),
        .run_end      (run_end),
        .failed_tests (failed_tests)
    );

    // Every pin has a weak pull-down, so a released pin reads zero.
    for (genvar i = 0; i < io_width; i++) begin : g_pin
        assign io[i] = drv_en[i] ? drv_val[i] : 1'bz;
        pulldown pd (io[i]);
    end

    always @(posedge BUS_CLK) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // Starts and ends on a falling edge. The strobe is held through the acknowledge edge.
    task automatic bus_cycle(input logic we, input logic [15:0] addr, input logic [7:0] data);
        wb_adr   = addr;
        wb_dat_i = data;
        wb_we    = we;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        @(negedge BUS_CLK);
        while (!wb_ack) begin
            @(negedge BUS_CLK);
        end
        @(negedge BUS_CLK);
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        exp_kind = 2'd0;
    endtask

    task automatic bus_read(input logic [15:0] addr, input logic [7:0] expected);
        exp_kind  = 2'd1;
        exp_addr  = addr;
        exp_value = io_width'(expected);
        bus_cycle(1'b0, addr, 8'h00);
    endtask

    task automatic pin_check(input logic [io_width-1:0] mask, input logic [io_width-1:0] value);
        exp_kind  = 2'd2;
        exp_mask  = mask;
        exp_value = value;
        @(negedge BUS_CLK);
        exp_kind  = 2'd0;
    endtask

    task automatic close_test();
        test_end = 1'b1;
        @(negedge BUS_CLK);
        test_end = 1'b0;
    endtask

    task automatic run_line();
        int                  f_addr;
        int                  f_data;
        int                  f_mask;
        int                  f_exp;
        logic [io_width-1:0] pattern;
        if (op == "T") begin
            if (in_test) begin
                close_test();
            end
            n       = $sscanf(line_buf, "%s %s", op, test_name);
            in_test = 1'b1;
        end else begin
            n = $sscanf(line_buf, "%s %h %h %h %h", op, f_addr, f_data, f_mask, f_exp);
            if (n != 5) begin
                $display("Vector line has too few fields: %0s", line_buf);
                line_errors++;
            end else if (op == "W") begin
                bus_cycle(1'b1, f_addr[15:0], f_data[7:0]);
            end else if (op == "R") begin
                bus_read(f_addr[15:0], f_exp[7:0]);
            end else if (op == "D") begin
                drv_val = f_data[io_width-1:0];
                drv_en  = f_mask[io_width-1:0];
            end else if (op == "U") begin
                drv_val = io_width'($urandom) & f_mask[io_width-1:0];
                drv_en  = f_mask[io_width-1:0];
            end else if (op == "P") begin
                pin_check(f_mask[io_width-1:0], f_exp[io_width-1:0]);
            end else if (op == "V") begin
                pattern = (drv_val & drv_en) >> (8 * f_data);  // Byte f_data of the pins.
                bus_read(f_addr[15:0], pattern[7:0]);
            end else begin
                $display("Unknown operation in vector line: %0s", line_buf);
                line_errors++;
            end
        end
    endtask

    task automatic run_vectors();
        while (!$feof(fd)) begin
            n = $fgets(line_buf, fd);
            if (n > 0) begin
                line_count++;
            end
        end
        $fclose(fd);
        cycle_limit = 8 * line_count + 50;
        fd          = $fopen("tests/gpio_vectors.txt", "r");
        repeat (2) @(negedge BUS_CLK);
        RST = 1'b0;
        while (!$feof(fd)) begin
            n = $fgets(line_buf, fd);
            if (n > 0 && $sscanf(line_buf, "%s", op) == 1 && op != "#") begin
                run_line();
            end
        end
        $fclose(fd);
        if (in_test) begin
            close_test();
        end
        run_end = 1'b1;
        @(negedge BUS_CLK);
        run_end = 1'b0;
        if (failed_tests == 0 && line_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
    endtask

    initial begin
        BUS_CLK   = 1'b0;
        RST       = 1'b1;
        wb_adr    = '0;
        wb_dat_i  = '0;
        wb_we     = 1'b0;
        wb_stb    = 1'b0;
        wb_cyc    = 1'b0;
        drv_val   = '0;
        drv_en    = '0;
        exp_kind  = 2'd0;
        exp_addr  = '0;
        exp_value = '0;
        exp_mask  = '0;
        test_name = "none";
        test_end  = 1'b0;
        run_end   = 1'b0;
        void'($urandom(26));
        fd        = $fopen("tests/gpio_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file tests/gpio_vectors.txt.");
            $display("Checks failed");
            $finish;
        end else begin
            run_vectors();
            $finish;
        end
    end

endmodule

/* tests/gpio_vectors.txt */
# op addr data mask expect, hex. T names a test, W writes, R reads, D and U drive pins in mask
# (U with random data), P checks pins in mask, V reads input byte <data> of the drive pattern.
T reset_state
R 1000 00 000 00
R 1003 00 000 00
R 1004 00 000 00
R 1005 00 000 00
R 1006 00 000 00
P 0000 000 0ff 000
T output_direction
W 1003 a5 000 00
P 0000 000 0ff 005
W 1005 30 000 00
P 0000 000 0ff 025
W 1005 f0 000 00
P 0000 000 0ff 0a5
W 1005 d0 000 00
P 0000 000 0ff 085
R 1003 00 000 a5
R 1005 00 000 d0
W 1004 3c 000 00
W 1006 81 000 00
R 1004 00 000 3c
R 1006 00 000 81
P 0000 000 f00 000
T input_readback
W 1003 00 000 00
W 1005 00 000 00
W 1006 00 000 00
D 0000 5a0 ff0 000
R 1001 00 000 a0
R 1002 00 000 05
D 0000 ff0 ff0 000
R 1002 00 000 0f
U 0000 000 ff0 000
V 1001 0 000 00
V 1002 1 000 00
U 0000 000 ff0 000
V 1001 0 000 00
V 1002 1 000 00
W 1001 ff 000 00
W 1002 ff 000 00
R 1003 00 000 00
R 1005 00 000 00
V 1001 0 000 00
D 0000 000 000 000
T soft_reset
W 1003 ff 000 00
W 1004 77 000 00
W 1005 f0 000 00
W 1006 0f 000 00
P 0000 000 0ff 0ff
W 1000 5a 000 00
R 1003 00 000 00
R 1004 00 000 00
R 1005 00 000 00
R 1006 00 000 00
P 0000 000 0ff 000
T window_handshake
W 1003 0f 000 00
W 0fff ff 000 00
W 1010 ff 000 00
W 1007 ff 000 00
R 0fff 00 000 00
R 1010 00 000 00
R 100f 00 000 00
R 1003 00 000 0f
R 1005 00 000 00
P 0000 000 0ff 00f

/* filelist.f */
logic/gpio_pkg.sv
logic/wb_to_ip.sv
logic/gpio_core.sv
logic/gpio_wb_top.sv
tests/gpio_checker.sv
tests/tb_gpio.sv

/* Bender.yml */
package:
  name: gpio_wb

sources:
  - logic/gpio_pkg.sv
  - logic/wb_to_ip.sv
  - logic/gpio_core.sv
  - logic/gpio_wb_top.sv
  - target: test
    files:
      - tests/gpio_checker.sv
      - tests/tb_gpio.sv
